/* dv/radio_input.txt */
# W adr dat | R adr expect | F last_chan i0 q0 i1 q1 i2 q2 | L lut_word
# K sample rise_cycles expect_i fall_cycles | D pd tx_i tx_q expect_dac
# Simplex with one receiver, rx0 follows the transmit phase
W 01 01000000
R 01 37EC8EC3
R 02 37EC8EC3
W 03 00100000
R 03 037EC8EC
W 04 00010000
R 04 0037EC8F
# Duplex set, rx0 keeps its own phase
W 00 00000004
R 00 00000004
W 02 00010000
R 02 0037EC8F
R 01 37EC8EC3
# last_chan clamped to 2, then framing
W 00 000000FF
R 00 00000014
F 2 123456 ABCDEF 800001 7FFFFF 000A5A FEDCBA
W 00 00000004
F 0 654321 0F0F0F 0 0 0 0
# CW ramp 2480 clocks each way
K 5A5A1234 9B2 4D80 9B3
# Predistortion bypass, table load, correction
D 0 1ABC 0011 ABC
L 01000123
L 00400020
L 10E11FF0
D 1 0100 0040 0F3
D 1 0040 0100 EED
D 0 F123 0000 123
R 2B 00000000

/* tb.f */
hdl/radio_pkg.sv
hdl/radio_cfg_regs.sv
hdl/rx_upstream_framer.sv
hdl/tx_baseband_keyer.sv
hdl/dac_predistorter.sv
hdl/radio_top.sv
dv/radio_asserts.sv
dv/tb_radio.sv

/* run_sim.sh */
#!/bin/bash
# Build the radio testbench with Verilator, run it and scan the log

LOG=sim.log
BUILD_DIR=obj_dir

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_radio --Mdir "$BUILD_DIR" -o Vtb_radio -f tb.f
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

"./$BUILD_DIR/Vtb_radio" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q 'All tests passed!' "$LOG"; then
  exit 0
fi
echo "Simulation did not pass, see $LOG"
exit 1

/* dv/tb_radio.sv */
`timescale 1ns/100ps

module tb_radio;
  import radio_pkg::*;

  // Clocks for one full CW ramp
  localparam int RAMP_CYCLES = int'(MAX_CW_LEVEL / CW_RAMP_STEP);
  // Two key cycles of rise and fall, then 100 vector lines at 100 clocks each
  localparam int CYCLE_LIMIT = 4 * RAMP_CYCLES + 100 * 100;

  logic             clk;
  logic             rst_n_i;
  wb_req_t          wb_req_i;
  wb_rsp_t          wb_rsp_o;
  phase_words_t     phase_o;
  rx_frame_t        rx_samples_i;
  logic             rx_strobe_i;
  logic [23:0]      rx_tdata_o;
  logic             rx_tvalid_o;
  logic             rx_tlast_o;
  logic             rx_tready_i;
  logic             cw_keydown_i;
  logic [31:0]      tx_tdata_i;
  logic             tx_tvalid_i;
  logic             tx_tready_o;
  iq16_t            tx_baseband_o;
  logic [31:0]      lr_tdata_i;
  logic             lr_tvalid_i;
  logic             lr_tready_o;
  iq16_t            tx_nco_i;
  logic [DAC_W-1:0] dac_o;

  // Hex fields of the current vector line
  logic [31:0] fld [0:6];
  int seed        = 41;
  int error_count = 0;
  int test_count  = 0;
  int fail_tests  = 0;
  int cycle_count = 0;

  radio_top DUT (.*);

  bind radio_top radio_asserts u_asserts (
    .clk         (clk),
    .rst_n_i     (rst_n_i),
    .wb_req_i    (wb_req_i),
    .wb_rsp_o    (wb_rsp_o),
    .rx_tdata_o  (rx_tdata_o),
    .rx_tvalid_o (rx_tvalid_o),
    .rx_tlast_o  (rx_tlast_o),
    .rx_tready_i (rx_tready_i)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // Run limit
  initial begin
    while (cycle_count < CYCLE_LIMIT) begin
      @(posedge clk);
      cycle_count++;
    end
    $display("Timeout: simulation still running after %0d clock cycles", CYCLE_LIMIT);
    $display("Test failures found");
    $finish;
  end

  // ----------------------------------------
  // Helpers
  // ----------------------------------------
  task automatic check_value(input string name, input logic [63:0] expected,
                             input logic [63:0] actual);
    if (actual !== expected) begin
      $display("CHECK FAILED %s expected %0h actual %0h", name, expected, actual);
      error_count++;
    end
  endtask

  // Frequency writes wait on the multiply, any other access acks on its first edge
  function automatic int expected_ack_cycles(input logic [5:0] adr, input logic we);
    if (we && adr inside {TX_FREQ, RX0_FREQ, RX1_FREQ, RX2_FREQ}) return 4;
    return 1;
  endfunction

  // Phase port word that belongs to a frequency address
  function automatic logic [31:0] phase_port_word(input logic [5:0] adr);
    case (adr)
      TX_FREQ:  return phase_o.tx;
      RX0_FREQ: return phase_o.rx[0];
      RX1_FREQ: return phase_o.rx[1];
      default:  return phase_o.rx[2];
    endcase
  endfunction

  // One Wishbone cycle, request held through the ack edge, then one idle clock
  task automatic bus_access(input logic [5:0] adr, input logic [31:0] dat, input logic we,
                            output logic [31:0] rdata, output int cycles);
    wb_req_i.adr = adr;
    wb_req_i.dat = dat;
    wb_req_i.we  = we;
    wb_req_i.cyc = 1'b1;
    wb_req_i.stb = 1'b1;
    cycles = 0;
    do begin
      @(negedge clk);
      cycles++;
    end while (!wb_rsp_o.ack);
    rdata = wb_rsp_o.dat;
    @(negedge clk);
    wb_req_i = '0;
    @(negedge clk);
  endtask

  // Expected beats are I then Q per channel up to last_chan
  task automatic send_frame(input string name);
    logic [23:0] beats [$];
    logic [31:0] rnd;
    int          total;
    int          beat;
    for (int c = 0; c < NUM_RX; c++) begin
      rx_samples_i.ch[c].i = fld[1 + 2 * c][23:0];
      rx_samples_i.ch[c].q = fld[2 + 2 * c][23:0];
      if (c <= fld[0]) begin
        beats.push_back(fld[1 + 2 * c][23:0]);
        beats.push_back(fld[2 + 2 * c][23:0]);
      end
    end
    total       = beats.size();
    beat        = 0;
    rx_strobe_i = 1'b1;
    while (beat < total) begin
      rnd         = $random(seed);
      rx_tready_i = rnd[0];
      // Both high now, so the beat moves on the coming edge
      if (rx_tvalid_o && rx_tready_i) begin
        check_value({name, " data"}, beats[beat], rx_tdata_o);
        check_value({name, " last"}, beat == total - 1, rx_tlast_o);
        beat++;
      end
      @(negedge clk);
    end
    // Strobe still high, no second frame
    repeat (8) begin
      rnd         = $random(seed);
      rx_tready_i = rnd[0];
      @(negedge clk);
      check_value({name, " restart"}, 0, rx_tvalid_o);
    end
    rx_strobe_i = 1'b0;
    repeat (2) @(negedge clk);
    check_value({name, " idle"}, 0, rx_tvalid_o);
    rx_tready_i = 1'b1;
  endtask

  task automatic key_cw(input string name);
    tx_tdata_i  = fld[0];
    tx_tvalid_i = 1'b1;
    @(negedge clk);
    tx_tvalid_i = 1'b0;
    @(negedge clk);
    check_value({name, " ready"}, 1, tx_tready_o);
    check_value({name, " idle sample"}, fld[0], tx_baseband_o);
    cw_keydown_i = 1'b1;
    repeat (fld[1]) @(negedge clk);
    // Full level on i, q silent
    check_value({name, " full i"}, fld[2][15:0], tx_baseband_o[31:16]);
    check_value({name, " full q"}, 0, tx_baseband_o[15:0]);
    cw_keydown_i = 1'b0;
    repeat (fld[3]) @(negedge clk);
    check_value({name, " released"}, fld[0], tx_baseband_o);
  endtask

  task automatic drive_dac(input string name);
    logic [31:0] rdata;
    int          cycles;
    // Sub index 0, mode in bits 17:16
    bus_access(PD_CTRL, {14'd0, fld[0][1:0], 16'd0}, 1'b1, rdata, cycles);
    tx_nco_i.i = fld[1][15:0];
    tx_nco_i.q = fld[2][15:0];
    @(negedge clk);
    tx_nco_i = '0;
    repeat (2) @(negedge clk);
    check_value(name, fld[3][11:0], dac_o);
  endtask

  task automatic load_lut(input string name);
    lr_tdata_i  = fld[0];
    lr_tvalid_i = 1'b1;
    check_value({name, " ready"}, 1, lr_tready_o);
    @(negedge clk);
    lr_tvalid_i = 1'b0;
  endtask

  task automatic skip_comment(input int fd);
    int ch;
    ch = $fgetc(fd);
    while (ch != 10 && ch != -1) ch = $fgetc(fd);
  endtask

  // ----------------------------------------
  // Vector loop
  // ----------------------------------------
  initial begin
    int          fd;
    int          code;
    int          errors_before;
    int          cycles;
    logic [7:0]  op;
    logic [31:0] rdata;
    string       name;
    logic        done;

    rst_n_i      = 1'b0;
    wb_req_i     = '0;
    rx_samples_i = '0;
    rx_strobe_i  = 1'b0;
    rx_tready_i  = 1'b1;
    cw_keydown_i = 1'b0;
    tx_tdata_i   = '0;
    tx_tvalid_i  = 1'b0;
    lr_tdata_i   = '0;
    lr_tvalid_i  = 1'b0;
    tx_nco_i     = '0;
    repeat (5) @(negedge clk);
    rst_n_i = 1'b1;
    @(negedge clk);

    fd = $fopen("dv/radio_input.txt", "r");
    if (fd == 0) begin
      $display("Cannot open the stimulus file dv/radio_input.txt");
      error_count++;
    end else begin
      done = 1'b0;
      while (!done) begin
        code = $fscanf(fd, " %c", op);
        if (code != 1) begin
          done = 1'b1;
        end else if (op == "#") begin
          skip_comment(fd);
        end else begin
          case (op)
            "W", "R": code = $fscanf(fd, "%h %h", fld[0], fld[1]) - 2;
            "F": code = $fscanf(fd, "%h %h %h %h %h %h %h", fld[0], fld[1], fld[2],
                                fld[3], fld[4], fld[5], fld[6]) - 7;
            "K", "D": code = $fscanf(fd, "%h %h %h %h", fld[0], fld[1], fld[2], fld[3]) - 4;
            "L": code = $fscanf(fd, "%h", fld[0]) - 1;
            default: code = -99;
          endcase
          if (code != 0) begin
            $display("Stimulus line with operation %c is unknown or malformed", op);
            error_count++;
            done = 1'b1;
          end else begin
            errors_before = error_count;
            case (op)
              "W": begin
                name = $sformatf("wb write %02h", fld[0][5:0]);
                bus_access(fld[0][5:0], fld[1], 1'b1, rdata, cycles);
                check_value({name, " ack"}, expected_ack_cycles(fld[0][5:0], 1'b1), cycles);
              end
              "R": begin
                name = $sformatf("wb read %02h", fld[0][5:0]);
                bus_access(fld[0][5:0], 32'd0, 1'b0, rdata, cycles);
                check_value({name, " ack"}, expected_ack_cycles(fld[0][5:0], 1'b0), cycles);
                check_value(name, fld[1], rdata);
                // Stored phase words also drive the phase port
                if (fld[0][5:0] inside {TX_FREQ, RX0_FREQ, RX1_FREQ, RX2_FREQ}) begin
                  check_value({name, " phase port"}, fld[1], phase_port_word(fld[0][5:0]));
                end
              end
              "F": begin
                name = $sformatf("frame last_chan %0d", fld[0]);
                send_frame(name);
              end
              "K": begin
                name = $sformatf("cw key sample %08h", fld[0]);
                key_cw(name);
              end
              "D": begin
                name = $sformatf("dac pd %0d i %04h q %04h", fld[0], fld[1], fld[2]);
                drive_dac(name);
              end
              "L": begin
                name = $sformatf("lut load %08h", fld[0]);
                load_lut(name);
              end
              default: ;
            endcase
            test_count++;
            if (error_count == errors_before) begin
              $display("PASS  %s", name);
            end else begin
              $display("FAIL  %s", name);
              fail_tests++;
            end
          end
        end
      end
      $fclose(fd);
    end

    $display("Summary: %0d tests, %0d failed, %0d check errors",
             test_count, fail_tests, error_count);
    if (error_count == 0 && test_count > 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule

/* dv/radio_asserts.sv */
`timescale 1ns/100ps

module radio_asserts (
  input logic               clk,
  input logic               rst_n_i,
  input radio_pkg::wb_req_t wb_req_i,
  input radio_pkg::wb_rsp_t wb_rsp_o,
  input logic [23:0]        rx_tdata_o,
  input logic               rx_tvalid_o,
  input logic               rx_tlast_o,
  input logic               rx_tready_i
);

  // ----------------------------------------
  // Wishbone
  // ----------------------------------------
  // Ack only while the host still holds the request
  ack_with_request: assert property (
    @(posedge clk) disable iff (!rst_n_i)
      wb_rsp_o.ack |-> (wb_req_i.cyc && wb_req_i.stb)
  ) else $error("Wishbone ack without cyc and stb");

  // ----------------------------------------
  // Upstream stream
  // ----------------------------------------
  // Stalled beat holds valid, data and last
  beat_held_on_stall: assert property (
    @(posedge clk) disable iff (!rst_n_i)
      (rx_tvalid_o && !rx_tready_i)
        |=> (rx_tvalid_o && $stable(rx_tdata_o) && $stable(rx_tlast_o))
  ) else $error("Upstream beat changed while tready was low");

  last_only_with_valid: assert property (
    @(posedge clk) disable iff (!rst_n_i) rx_tlast_o |-> rx_tvalid_o
  ) else $error("Upstream tlast without tvalid");

endmodule

/* hdl/radio_top.sv */
`timescale 1ns/100ps

module radio_top (
  input  logic                        clk,
  input  logic                        rst_n_i,
  // Wishbone configuration port
  input  radio_pkg::wb_req_t          wb_req_i,
  output radio_pkg::wb_rsp_t          wb_rsp_o,
  output radio_pkg::phase_words_t     phase_o,
  // Receiver samples and upstream stream
  input  radio_pkg::rx_frame_t        rx_samples_i,
  input  logic                        rx_strobe_i,
  output logic [23:0]                 rx_tdata_o,
  output logic                        rx_tvalid_o,
  output logic                        rx_tlast_o,
  input  logic                        rx_tready_i,
  // Transmit baseband
  input  logic                        cw_keydown_i,
  input  logic [31:0]                 tx_tdata_i,
  input  logic                        tx_tvalid_i,
  output logic                        tx_tready_o,
  output radio_pkg::iq16_t            tx_baseband_o,
  // Predistortion tables and DAC
  input  logic [31:0]                 lr_tdata_i,
  input  logic                        lr_tvalid_i,
  output logic                        lr_tready_o,
  input  radio_pkg::iq16_t            tx_nco_i,
  output logic [radio_pkg::DAC_W-1:0] dac_o
);
  import radio_pkg::*;

  radio_cfg_t cfg;

  // Configuration block steering the datapaths
  radio_cfg_regs u_cfg_regs (
    .clk      (clk),
    .rst_n_i  (rst_n_i),
    .wb_req_i (wb_req_i),
    .wb_rsp_o (wb_rsp_o),
    .cfg_o    (cfg),
    .phase_o  (phase_o)
  );

  // Framer only looks at last_chan
  rx_upstream_framer u_framer (
    .clk          (clk),
    .rst_n_i      (rst_n_i),
    .cfg_i        (cfg),
    .rx_samples_i (rx_samples_i),
    .rx_strobe_i  (rx_strobe_i),
    .rx_tdata_o   (rx_tdata_o),
    .rx_tvalid_o  (rx_tvalid_o),
    .rx_tlast_o   (rx_tlast_o),
    .rx_tready_i  (rx_tready_i)
  );

  tx_baseband_keyer u_keyer (
    .clk           (clk),
    .rst_n_i       (rst_n_i),
    .cw_keydown_i  (cw_keydown_i),
    .tx_tdata_i    (tx_tdata_i),
    .tx_tvalid_i   (tx_tvalid_i),
    .tx_tready_o   (tx_tready_o),
    .tx_baseband_o (tx_baseband_o)
  );

  dac_predistorter u_predist (
    .clk         (clk),
    .rst_n_i     (rst_n_i),
    .pd_mode_i   (cfg.pd_mode),
    .lr_tdata_i  (lr_tdata_i),
    .lr_tvalid_i (lr_tvalid_i),
    .lr_tready_o (lr_tready_o),
    .tx_nco_i    (tx_nco_i),
    .dac_o       (dac_o)
  );

endmodule

/* hdl/dac_predistorter.sv */
`timescale 1ns/100ps

module dac_predistorter (
  input  logic                      clk,
  input  logic                      rst_n_i,
  input  radio_pkg::pd_mode_e       pd_mode_i,
  input  logic [31:0]               lr_tdata_i,
  input  logic                      lr_tvalid_i,
  output logic                      lr_tready_o,
  input  radio_pkg::iq16_t          tx_nco_i,
  output logic [radio_pkg::DAC_W-1:0] dac_o
);
  import radio_pkg::*;

  // Out of phase term in lut_i, in phase term in lut_q
  // Indexes are two's complement order
  logic signed [12:0] lut_i [0:(1<<LUT_AW)-1];
  logic signed [12:0] lut_q [0:(1<<LUT_AW)-1];
  lut_write_t         lw;
  logic signed [15:0] i1, q1, s1;
  logic signed [15:0] i2, q2, r2;
  logic signed [15:0] distorted;

  assign lw.tdata  = lr_tdata_i;
  assign lw.tvalid = lr_tvalid_i;
  assign lr_tready_o = 1'b1;

  // ----------------------------------------
  // Table load from the side stream
  // ----------------------------------------
  always_ff @(posedge clk) begin
    if (lw.tvalid) begin
      // Bit 28 picks the Q table
      if (lw.tdata[28]) lut_q[lw.tdata[16 +: LUT_AW]] <= lw.tdata[12:0];
      else lut_i[lw.tdata[16 +: LUT_AW]] <= lw.tdata[12:0];
    end
  end

  // ----------------------------------------
  // Correction pipeline
  // ----------------------------------------
  always_ff @(posedge clk) begin
    // Stage 1 inputs and their sum
    i1 <= tx_nco_i.i;
    q1 <= tx_nco_i.q;
    s1 <= tx_nco_i.i + tx_nco_i.q;
    // Stage 2, roughly (i+q)/sqrt(2) scaled up by 2
    i2 <= i1;
    q2 <= q1;
    r2 <= s1 + (s1 >>> 2) + (s1 >>> 3) + (s1 >>> 5);
  end

  assign distorted = lut_i[i2[LUT_AW-1:0]] - lut_i[q2[LUT_AW-1:0]] + lut_q[r2[LUT_AW:1]];

  // Stage 3, mode select into the DAC word
  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      dac_o <= '0;
    end else if (pd_mode_i == PD_ON) begin
      dac_o <= distorted[DAC_W-1:0];
    end else begin
      dac_o <= i2[DAC_W-1:0];
    end
  end

endmodule

/* hdl/tx_baseband_keyer.sv */
`timescale 1ns/100ps

module tx_baseband_keyer (
  input  logic             clk,
  input  logic             rst_n_i,
  input  logic             cw_keydown_i,
  input  logic [31:0]      tx_tdata_i,
  input  logic             tx_tvalid_i,
  output logic             tx_tready_o,
  output radio_pkg::iq16_t tx_baseband_o
);
  import radio_pkg::*;

  cw_state_e   cw_state_q;
  logic [17:0] level_q;
  iq16_t       sample_q;
  iq16_t       cw_word;
  iq16_t       baseband_q;

  // No back-pressure toward the sample source
  assign tx_tready_o = 1'b1;

  // Envelope scaled down by 8 onto i, q silent
  assign cw_word.i = {1'b0, level_q[17:3]};
  assign cw_word.q = 16'sd0;

  // ----------------------------------------
  // Sample latch and CW envelope
  // ----------------------------------------
  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      sample_q   <= '0;
      cw_state_q <= CW_OFF;
      level_q    <= 18'd0;
      baseband_q <= '0;
    end else begin
      // I in the upper half, Q in the lower half
      if (tx_tvalid_i) sample_q <= tx_tdata_i;
      case (cw_state_q)
        CW_OFF: begin
          level_q <= 18'd0;
          if (cw_keydown_i) cw_state_q <= CW_RISE;
        end
        CW_RISE: begin
          // Linear rise, saturate at full level
          if (level_q > MAX_CW_LEVEL - CW_RAMP_STEP) level_q <= MAX_CW_LEVEL;
          else level_q <= level_q + CW_RAMP_STEP;
          if (!cw_keydown_i) cw_state_q <= CW_FALL;
        end
        CW_FALL: begin
          if (level_q == 18'd0) cw_state_q <= CW_OFF;
          else if (level_q < CW_RAMP_STEP) level_q <= 18'd0;
          else level_q <= level_q - CW_RAMP_STEP;
        end
        default: cw_state_q <= CW_OFF;
      endcase
      // Envelope replaces the sample for the whole ramp
      baseband_q <= (cw_state_q != CW_OFF) ? cw_word : sample_q;
    end
  end

  assign tx_baseband_o = baseband_q;

endmodule

/* hdl/rx_upstream_framer.sv */
`timescale 1ns/100ps

module rx_upstream_framer (
  input  logic                  clk,
  input  logic                  rst_n_i,
  input  radio_pkg::radio_cfg_t cfg_i,
  input  radio_pkg::rx_frame_t  rx_samples_i,
  input  logic                  rx_strobe_i,
  output logic [23:0]           rx_tdata_o,
  output logic                  rx_tvalid_o,
  output logic                  rx_tlast_o,
  input  logic                  rx_tready_i
);
  import radio_pkg::*;

  ups_state_e                   state_q;
  logic [$clog2(NUM_RX)-1:0]    chan_q;
  // Channel count frozen for the whole frame
  logic [$clog2(NUM_RX)-1:0]    last_q;
  rx_frame_t                    frame_q;
  rx_sample_t                   cur;

  assign cur = frame_q.ch[chan_q];

  // ----------------------------------------
  // Beat sequencer
  // ----------------------------------------
  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      state_q <= WAIT_STROBE;
      chan_q  <= '0;
      last_q  <= '0;
    end else begin
      case (state_q)
        WAIT_STROBE: begin
          chan_q <= '0;
          if (rx_strobe_i && rx_tready_i) begin
            // last_chan is already clamped below NUM_RX
            last_q  <= cfg_i.last_chan[$clog2(NUM_RX)-1:0];
            state_q <= SEND_I;
          end
        end
        SEND_I: if (rx_tready_i) state_q <= SEND_Q;
        SEND_Q: begin
          if (rx_tready_i) begin
            if (chan_q == last_q) begin
              state_q <= WAIT_CLEAR;
            end else begin
              chan_q  <= chan_q + 1'b1;
              state_q <= SEND_I;
            end
          end
        end
        // Hold off until the receiver strobe drops
        WAIT_CLEAR: if (!rx_strobe_i) state_q <= WAIT_STROBE;
        default: state_q <= WAIT_STROBE;
      endcase
    end
  end

  // Snapshot of all channels, taken at frame start
  always_ff @(posedge clk) begin
    if (state_q == WAIT_STROBE && rx_strobe_i && rx_tready_i) frame_q <= rx_samples_i;
  end

  // Outputs come from state only, so they hold while tready is low
  assign rx_tvalid_o = (state_q == SEND_I) || (state_q == SEND_Q);
  assign rx_tdata_o  = (state_q == SEND_I) ? cur.i : cur.q;
  assign rx_tlast_o  = (state_q == SEND_Q) && (chan_q == last_q);

endmodule

/* hdl/radio_cfg_regs.sv */
`timescale 1ns/100ps

module radio_cfg_regs (
  input  logic                    clk,
  input  logic                    rst_n_i,
  input  radio_pkg::wb_req_t      wb_req_i,
  output radio_pkg::wb_rsp_t      wb_rsp_o,
  output radio_pkg::radio_cfg_t   cfg_o,
  output radio_pkg::phase_words_t phase_o
);
  import radio_pkg::*;

  cfg_state_e   state_q;
  logic         ack_q;
  logic [31:0]  rd_dat_q;
  radio_cfg_t   cfg_q;
  phase_words_t phase_q;
  // Frequency write in flight
  logic [5:0]   addr_q;
  logic [31:0]  freq_word_q;
  logic [63:0]  prod_q;
  logic [31:0]  phase_new_q;
  logic         req_new;
  logic         is_freq;
  logic         rx0_follows_tx;
  logic [4:0]   last_chan_w;
  logic [31:0]  rd_mux;

  // A request still held after its ack is not taken again
  assign req_new = wb_req_i.cyc && wb_req_i.stb && !ack_q;
  assign is_freq = wb_req_i.adr inside {TX_FREQ, RX0_FREQ, RX1_FREQ, RX2_FREQ};
  // Simplex single receiver, rx0 tracks the transmit frequency
  assign rx0_follows_tx = !cfg_q.duplex && (cfg_q.last_chan == 5'd0);

  // Clamp last_chan to the receivers that exist
  assign last_chan_w = (wb_req_i.dat[7:3] > 5'(NUM_RX - 1)) ? 5'(NUM_RX - 1)
                                                            : wb_req_i.dat[7:3];

  always_comb begin
    case (wb_req_i.adr)
      CTRL:     rd_mux = {24'd0, cfg_q.last_chan, cfg_q.duplex, 2'b00};
      TX_FREQ:  rd_mux = phase_q.tx;
      RX0_FREQ: rd_mux = phase_q.rx[0];
      RX1_FREQ: rd_mux = phase_q.rx[1];
      RX2_FREQ: rd_mux = phase_q.rx[2];
      default:  rd_mux = 32'd0;
    endcase
  end

  // ----------------------------------------
  // Bus FSM and register writes
  // ----------------------------------------
  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      state_q <= IDLE;
      ack_q   <= 1'b0;
      cfg_q   <= '0;
      phase_q <= '0;
    end else begin
      ack_q <= 1'b0;
      case (state_q)
        IDLE: begin
          if (req_new) begin
            if (wb_req_i.we && is_freq) begin
              state_q <= MUL1;
            end else begin
              // Plain register access, ack next edge
              ack_q <= 1'b1;
              if (wb_req_i.we && wb_req_i.adr == CTRL) begin
                cfg_q.last_chan <= last_chan_w;
                cfg_q.duplex    <= wb_req_i.dat[2];
              end
              // Sub index 0 only
              if (wb_req_i.we && wb_req_i.adr == PD_CTRL && wb_req_i.dat[31:24] == 8'h00) begin
                cfg_q.pd_mode <= (wb_req_i.dat[17:16] == 2'd1) ? PD_ON : PD_OFF;
              end
            end
          end
        end
        MUL1: state_q <= MUL2;
        MUL2: state_q <= COMMIT;
        COMMIT: begin
          state_q <= IDLE;
          ack_q   <= 1'b1;
          case (addr_q)
            TX_FREQ: begin
              phase_q.tx <= phase_new_q;
              if (rx0_follows_tx) phase_q.rx[0] <= phase_new_q;
            end
            RX0_FREQ: phase_q.rx[0] <= rx0_follows_tx ? phase_q.tx : phase_new_q;
            RX1_FREQ: phase_q.rx[1] <= phase_new_q;
            RX2_FREQ: phase_q.rx[2] <= phase_new_q;
            default: ;
          endcase
        end
        default: state_q <= IDLE;
      endcase
    end
  end

  // ----------------------------------------
  // Phase pipeline, two cycles for the multiply
  // ----------------------------------------
  always_ff @(posedge clk) begin
    if (state_q == IDLE && req_new) begin
      addr_q      <= wb_req_i.adr;
      freq_word_q <= wb_req_i.dat;
      rd_dat_q    <= rd_mux;
    end
    prod_q      <= {32'd0, freq_word_q} * {32'd0, PHASE_MULT} + {32'd0, PHASE_ROUND};
    // Bits 56:25 hold the rounded phase increment
    phase_new_q <= prod_q[PHASE_LSB +: 32];
  end

  assign wb_rsp_o.dat = rd_dat_q;
  assign wb_rsp_o.ack = ack_q;
  assign cfg_o        = cfg_q;
  assign phase_o      = phase_q;

endmodule

/* hdl/radio_pkg.sv */
package radio_pkg;

  // ----------------------------------------
  // Sizes and constants
  // ----------------------------------------
  localparam int NUM_RX = 3;

  // Tuning word to phase increment, 76.8 MHz clock
  localparam logic [31:0] PHASE_MULT  = 32'd1876499845;
  localparam logic [31:0] PHASE_ROUND = 32'd16777216;
  // Low bit of the 32-bit phase slice in the 64-bit product
  localparam int PHASE_LSB = 25;

  // Full CW envelope, 8x the peak NCO input
  localparam logic [17:0] MAX_CW_LEVEL = 18'h26C00;
  localparam logic [17:0] CW_RAMP_STEP = 18'd64;

  localparam int LUT_AW = 12;
  localparam int DAC_W  = 12;

  // ----------------------------------------
  // Encodings
  // ----------------------------------------
  typedef enum logic [5:0] {
    CTRL     = 6'h00,
    TX_FREQ  = 6'h01,
    RX0_FREQ = 6'h02,
    RX1_FREQ = 6'h03,
    RX2_FREQ = 6'h04,
    PD_CTRL  = 6'h2B
  } reg_addr_e;

  typedef enum logic [1:0] {PD_OFF = 2'd0, PD_ON = 2'd1} pd_mode_e;
  typedef enum logic [1:0] {IDLE, MUL1, MUL2, COMMIT} cfg_state_e;
  typedef enum logic [1:0] {WAIT_STROBE, SEND_I, SEND_Q, WAIT_CLEAR} ups_state_e;
  typedef enum logic [1:0] {CW_OFF, CW_RISE, CW_FALL} cw_state_e;

  // ----------------------------------------
  // Bundles
  // ----------------------------------------
  typedef struct packed {
    logic [5:0]  adr;
    logic [31:0] dat;
    logic        we;
    logic        cyc;
    logic        stb;
  } wb_req_t;

  typedef struct packed {
    logic [31:0] dat;
    logic        ack;
  } wb_rsp_t;

  typedef struct packed {
    logic signed [15:0] i;
    logic signed [15:0] q;
  } iq16_t;

  typedef struct packed {
    logic signed [23:0] i;
    logic signed [23:0] q;
  } rx_sample_t;

  // Channel 0 sits in the low bits
  typedef struct packed {
    rx_sample_t [NUM_RX-1:0] ch;
  } rx_frame_t;

  typedef struct packed {
    logic [31:0]              tx;
    logic [NUM_RX-1:0] [31:0] rx;
  } phase_words_t;

  typedef struct packed {
    logic [4:0] last_chan;
    logic       duplex;
    pd_mode_e   pd_mode;
  } radio_cfg_t;

  typedef struct packed {
    logic [31:0] tdata;
    logic        tvalid;
  } lut_write_t;

endpackage
